/* common/ea_consts.svh */
`ifndef EA_CONSTS_SVH
`define EA_CONSTS_SVH

`define EA_ADDR_W   24      // Effective address bits
`define OPQ_DEPTH   8       // Prefetch queue bytes

`define EA_NULL_REG 8'h40   // Always reads as zero
`define EA_STEP_N   3       // Valid step codes

`endif

/* common/cpu_regs_pkg.sv */
package cpu_regs_pkg;

    typedef logic [7:0]  reg_code_t;   // Codes 0xC0 and up hit the bank
    typedef logic [31:0] reg_val_t;
    typedef logic [3:0]  reg_idx_t;    // Longword slot
    typedef logic [1:0]  step_t;       // Step of 1, 2 or 4 bytes

    // Lower codes read as zero
    function automatic logic code_hit(input reg_code_t code);
        return code[7:6] == 2'b11;
    endfunction

    function automatic reg_idx_t code_idx(input reg_code_t code);
        return code[5:2];              // Byte lane bits dropped
    endfunction

    // Short 3-bit register field to its longword code
    function automatic reg_code_t long_code(input logic [2:0] r);
        return {3'b111, r, 2'b00};     // XWA at 0xE0 through XSP at 0xFC
    endfunction

endpackage

/* common/ea_pkg.sv */
package ea_pkg;

    typedef logic [23:0] ea_addr_t;
    typedef logic [4:0]  ea_mode_t;    // Opcode bit 6 with bits 3..0
    typedef logic [2:0]  fetch_cnt_t;  // Bytes popped per decode

    typedef enum logic [1:0] {
        OFF_LATCH = 2'd0,              // Latched immediate or displacement
        OFF_R8    = 2'd1,              // Signed byte register
        OFF_R16   = 2'd2               // Signed word register
    } off_src_t;

    // Indexed modes with opcode bit 6 set
    localparam ea_mode_t MODE_ABS8    = 5'h10;
    localparam ea_mode_t MODE_ABS16   = 5'h11;
    localparam ea_mode_t MODE_ABS24   = 5'h12;
    localparam ea_mode_t MODE_EXT     = 5'h13;   // (r32) (r32+d16) (r32+r8) (r32+r16)
    localparam ea_mode_t MODE_PREDEC  = 5'h14;
    localparam ea_mode_t MODE_POSTINC = 5'h15;

    // Step code to byte count
    function automatic cpu_regs_pkg::reg_val_t step_val(input cpu_regs_pkg::step_t s);
        return 32'd1 << s;
    endfunction

endpackage

/* source/op_queue.sv */
`timescale 1ns/100ps

`include "ea_consts.svh"

module op_queue (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              byte_valid,
    input  logic [7:0]                        byte_data,
    output logic [$clog2(`OPQ_DEPTH+1)-1:0]   byte_space,
    input  ea_pkg::fetch_cnt_t                fetched,
    output logic [31:0]                       op,
    output logic                              op_ready
);
    localparam int PTR_W = $clog2(`OPQ_DEPTH);
    localparam int CNT_W = $clog2(`OPQ_DEPTH+1);

    logic [7:0]       mem [`OPQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op[8*i +: 8] = mem[PTR_W'(rd_ptr + PTR_W'(i))];   // Wraps on depth
        end
        byte_space = CNT_W'(`OPQ_DEPTH) - count;
        op_ready   = count >= CNT_W'(4);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (byte_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + PTR_W'(fetched);
            count  <= count + CNT_W'(byte_valid) - CNT_W'(fetched);   // Push and pop together
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            mem[wr_ptr] <= byte_data;
        end
    end

endmodule

/* source/reg_bank.sv */
`timescale 1ns/100ps

module reg_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    reg_wr,
    input  cpu_regs_pkg::reg_code_t reg_wr_code,
    input  cpu_regs_pkg::reg_val_t  reg_wr_data,
    input  cpu_regs_pkg::reg_code_t base_code,
    input  cpu_regs_pkg::reg_code_t aux_code,
    output cpu_regs_pkg::reg_val_t  base_val,
    output logic [15:0]             aux_val,
    input  logic                    reg_upd,
    input  logic                    reg_dec,
    input  cpu_regs_pkg::step_t     reg_step
);
    import ea_pkg::*;
    import cpu_regs_pkg::*;

    reg_val_t regs [16];
    reg_val_t aux_long;
    reg_val_t upd_val;
    reg_idx_t base_idx;
    reg_idx_t aux_idx;
    reg_idx_t wr_idx;

    always_comb begin
        base_idx = code_idx(base_code);
        aux_idx  = code_idx(aux_code);
        wr_idx   = code_idx(reg_wr_code);
        base_val = code_hit(base_code) ? regs[base_idx] : '0;
        aux_long = code_hit(aux_code) ? regs[aux_idx] : '0;
        aux_val  = 16'(aux_long >> {aux_code[1:0], 3'b000});   // Lane picked by code bits 1..0
        upd_val  = reg_dec ? base_val - step_val(reg_step)
                           : base_val + step_val(reg_step);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (reg_upd && code_hit(base_code)) begin
                regs[base_idx] <= upd_val;      // Step write-back
            end
            // Outside load overrides write-back on the same register
            if (reg_wr && code_hit(reg_wr_code)) begin
                regs[wr_idx] <= reg_wr_data;
            end
        end
    end

endmodule

/* ea_decode/ea_decode.sv */
`timescale 1ns/100ps

`include "ea_consts.svh"

module ea_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [31:0]             op,
    input  logic                    idx_en,
    output ea_pkg::fetch_cnt_t      fetched,
    output cpu_regs_pkg::reg_code_t base_code,
    output cpu_regs_pkg::reg_code_t aux_code,
    input  cpu_regs_pkg::reg_val_t  base_val,
    input  logic [15:0]             aux_val,
    output logic                    reg_upd,
    output logic                    reg_dec,
    output cpu_regs_pkg::step_t     reg_step,
    output logic                    ea_valid,
    output ea_pkg::ea_addr_t        ea_addr
);
    import ea_pkg::*;
    import cpu_regs_pkg::*;

    ea_mode_t  mode;
    ea_mode_t  nx_mode;
    off_src_t  off_src;
    off_src_t  nx_off_src;
    ea_addr_t  offset;
    ea_addr_t  nx_offset;
    ea_addr_t  off_val;
    reg_code_t nx_base_code;
    reg_code_t nx_aux_code;
    step_t     nx_step;
    logic      phase;
    logic      nx_phase;
    logic      nx_done;
    logic      nx_upd;
    logic      nx_dec;
    logic      go;

    assign go = cen & idx_en & ~ea_valid;   // Decode only while a request is open

    always_comb begin
        case (off_src)
            OFF_R8:  off_val = {{(`EA_ADDR_W-8){aux_val[7]}}, aux_val[7:0]};
            OFF_R16: off_val = {{(`EA_ADDR_W-16){aux_val[15]}}, aux_val};
            default: off_val = offset;
        endcase
        ea_addr = base_val[`EA_ADDR_W-1:0] + off_val;
    end

    always_comb begin
        fetched      = '0;
        nx_mode      = mode;
        nx_off_src   = off_src;
        nx_offset    = offset;
        nx_base_code = base_code;
        nx_aux_code  = aux_code;
        nx_step      = reg_step;
        nx_dec       = reg_dec;
        nx_phase     = phase;
        nx_done      = 1'b0;
        nx_upd       = 1'b0;
        if (go) begin
            if (!phase) begin
                nx_mode     = {op[6], op[3:0]};
                nx_off_src  = OFF_LATCH;
                nx_offset   = '0;
                nx_aux_code = `EA_NULL_REG;
                nx_done     = 1'b1;
                fetched     = 3'd2;
                casez ({op[6], op[3:0]})
                    5'b0_????: begin                    // (r) and (r+d8)
                        nx_base_code = long_code(op[2:0]);
                        if (op[3]) begin
                            nx_offset = {{(`EA_ADDR_W-8){op[15]}}, op[15:8]};
                        end
                        fetched = op[3] ? 3'd2 : 3'd1;
                    end
                    MODE_ABS8: begin
                        nx_base_code = `EA_NULL_REG;
                        nx_offset    = {{(`EA_ADDR_W-8){1'b0}}, op[15:8]};
                    end
                    MODE_ABS16, MODE_ABS24: begin       // Upper bytes follow
                        nx_base_code = `EA_NULL_REG;
                        nx_offset    = {{(`EA_ADDR_W-8){1'b0}}, op[15:8]};
                        nx_done      = 1'b0;
                        nx_phase     = 1'b1;
                    end
                    MODE_EXT: begin
                        nx_base_code = {op[15:10], 2'b00};
                        case (op[9:8])
                            2'd0: nx_done = 1'b1;       // Plain (r32)
                            2'd1: begin
                                nx_done  = 1'b0;
                                nx_phase = 1'b1;
                            end
                            default: begin              // Register pair next
                                nx_done    = 1'b0;
                                nx_phase   = 1'b1;
                                nx_off_src = op[10] ? OFF_R16 : OFF_R8;
                            end
                        endcase
                    end
                    MODE_PREDEC, MODE_POSTINC: begin
                        nx_base_code = {op[15:10], 2'b00};
                        nx_step      = (op[9:8] < `EA_STEP_N) ? op[9:8]
                                                              : step_t'(`EA_STEP_N - 1);
                        nx_dec       = ~op[0];
                        nx_upd       = 1'b1;
                        // Pre-decrement points below the old base
                        nx_offset    = op[0] ? '0 : ea_addr_t'(-step_val(nx_step));
                    end
                    default: begin                      // Unused code, skip one byte
                        nx_base_code = `EA_NULL_REG;
                        fetched      = 3'd1;
                    end
                endcase
            end else begin
                nx_phase = 1'b0;
                nx_done  = 1'b1;
                case (mode)
                    MODE_ABS16: begin
                        nx_offset[`EA_ADDR_W-1:8] = {8'd0, op[7:0]};
                        fetched = 3'd1;
                    end
                    MODE_ABS24: begin
                        nx_offset[`EA_ADDR_W-1:8] = op[15:0];
                        fetched = 3'd2;
                    end
                    default: begin                      // Second word of extended form
                        fetched = 3'd2;
                        if (off_src == OFF_LATCH) begin
                            nx_offset = {{(`EA_ADDR_W-16){op[15]}}, op[15:0]};
                        end else begin
                            nx_base_code = op[7:0];
                            nx_aux_code  = op[15:8];
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode      <= '0;
            off_src   <= OFF_LATCH;
            offset    <= '0;
            base_code <= `EA_NULL_REG;
            aux_code  <= `EA_NULL_REG;
            reg_step  <= '0;
            reg_dec   <= 1'b0;
            reg_upd   <= 1'b0;
            phase     <= 1'b0;
            ea_valid  <= 1'b0;
        end else begin
            mode      <= nx_mode;
            off_src   <= nx_off_src;
            base_code <= nx_base_code;
            aux_code  <= nx_aux_code;
            reg_step  <= nx_step;
            reg_dec   <= nx_dec;
            reg_upd   <= go & nx_upd;       // Single pulse with the ea_valid rise
            if (!idx_en) begin
                ea_valid <= 1'b0;
                phase    <= 1'b0;
            end else if (go) begin
                ea_valid <= nx_done;
                phase    <= nx_phase;
            end
            // Base register moves on write-back so the offset follows it
            if (reg_upd) begin
                offset <= reg_dec ? '0 : ea_addr_t'(-step_val(reg_step));
            end else begin
                offset <= nx_offset;
            end
        end
    end

endmodule

/* source/ea_unit.sv */
`timescale 1ns/100ps

`include "ea_consts.svh"

module ea_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              byte_valid,
    input  logic [7:0]                        byte_data,
    output logic [$clog2(`OPQ_DEPTH+1)-1:0]   byte_space,
    input  logic                              reg_wr,
    input  cpu_regs_pkg::reg_code_t           reg_wr_code,
    input  cpu_regs_pkg::reg_val_t            reg_wr_data,
    input  logic                              idx_en,
    output logic                              ea_valid,
    output ea_pkg::ea_addr_t                  ea_addr
);
    import ea_pkg::*;
    import cpu_regs_pkg::*;

    logic [31:0] op;            // Oldest byte in bits 7..0
    logic        op_ready;
    fetch_cnt_t  fetched;
    reg_code_t   base_code;
    reg_code_t   aux_code;
    reg_val_t    base_val;
    logic [15:0] aux_val;
    logic        reg_upd;
    logic        reg_dec;
    step_t       reg_step;

    op_queue i_op_queue (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_space (byte_space),
        .fetched    (fetched),
        .op         (op),
        .op_ready   (op_ready)
    );

    ea_decode i_ea_decode (
        .clk        (clk),
        .rst        (rst),
        .cen        (op_ready),     // Stall while window is short
        .op         (op),
        .idx_en     (idx_en),
        .fetched    (fetched),
        .base_code  (base_code),
        .aux_code   (aux_code),
        .base_val   (base_val),
        .aux_val    (aux_val),
        .reg_upd    (reg_upd),
        .reg_dec    (reg_dec),
        .reg_step   (reg_step),
        .ea_valid   (ea_valid),
        .ea_addr    (ea_addr)
    );

    reg_bank i_reg_bank (
        .clk         (clk),
        .rst         (rst),
        .reg_wr      (reg_wr),
        .reg_wr_code (reg_wr_code),
        .reg_wr_data (reg_wr_data),
        .base_code   (base_code),
        .aux_code    (aux_code),
        .base_val    (base_val),
        .aux_val     (aux_val),
        .reg_upd     (reg_upd),
        .reg_dec     (reg_dec),
        .reg_step    (reg_step)
    );

endmodule

/* dv/ea_unit_tb.sv */
`timescale 1ns/100ps

`include "ea_consts.svh"

module ea_unit_tb;

    logic        clk        = 1'b0;
    logic        byte_valid = 1'b0;     // Owned by the feeder
    logic [7:0]  byte_data  = 8'h00;
    logic        feed_on    = 1'b0;
    logic        rst;
    logic [3:0]  byte_space;
    logic        reg_wr;
    logic [7:0]  reg_wr_code;
    logic [31:0] reg_wr_data;
    logic        idx_en;
    logic        ea_valid;
    logic [23:0] ea_addr;

    logic [31:0] mregs [16];            // Model copy of the bank
    logic [7:0]  stream [$];            // Instruction bytes not yet fed
    logic [23:0] exp_q [$];
    logic [23:0] exp_addr;

    ea_unit i_ea_unit (.*);

    always #10 clk = ~clk;

    // Byte in flight this edge still counts against the free space
    always @(posedge clk) begin
        if (feed_on && stream.size() > 0 && byte_space > {3'b000, byte_valid}) begin
            byte_valid <= 1'b1;
            byte_data  <= stream.pop_front();
        end else begin
            byte_valid <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) ea_valid |-> ea_addr == exp_addr)
        else report_value("ea_addr", $sampled(ea_addr), $sampled(exp_addr));

    assert property (@(posedge clk) disable iff (rst) !idx_en |=> !ea_valid)
        else report_value("ea_valid", $sampled(ea_valid), 32'h0);

    // Result is held for as long as the request stays up
    assert property (@(posedge clk) disable iff (rst) idx_en && ea_valid |=> ea_valid)
        else report_value("ea_valid", $sampled(ea_valid), 32'h1);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        abort_run($sformatf("error %s got 0x%0h expected 0x%0h", name, got, want));
    endtask

    function automatic logic [23:0] sext8(input logic [7:0] b);
        return {{16{b[7]}}, b};
    endfunction

    // (r) or (r+d8) with the short 3-bit register field
    function automatic void add_short(input logic [2:0] r, input logic d8_on,
                                      input logic [7:0] d8);
        stream.push_back({4'b1000, d8_on, r});
        if (d8_on)
            stream.push_back(d8);
        exp_q.push_back(mregs[{1'b1, r}][23:0] + (d8_on ? sext8(d8) : 24'h0));
    endfunction

    function automatic void add_abs(input int n, input logic [23:0] a);
        stream.push_back(8'h40 + 8'(n - 1));
        for (int i = 0; i < n; i++)
            stream.push_back(a[8*i +: 8]);
        exp_q.push_back(n == 1 ? {16'h0, a[7:0]} : n == 2 ? {8'h0, a[15:0]} : a);
    endfunction

    function automatic void add_ext(input logic [3:0] idx, input logic d16_on,
                                    input logic [15:0] d16);
        stream.push_back(8'h43);
        stream.push_back({2'b11, idx, 1'b0, d16_on});
        if (d16_on) begin
            stream.push_back(d16[7:0]);
            stream.push_back(d16[15:8]);
        end
        exp_q.push_back(mregs[idx][23:0] + (d16_on ? {{8{d16[15]}}, d16} : 24'h0));
    endfunction

    // (r32+r8) or (r32+r16), lane picks the byte position in the index register
    function automatic void add_pair(input logic wide, input logic [3:0] b_idx,
                                     input logic [3:0] a_idx, input logic [1:0] lane);
        logic [31:0] part;
        part = mregs[a_idx] >> {lane, 3'b000};
        stream.push_back(8'h43);
        stream.push_back(wide ? 8'hc6 : 8'hc2);
        stream.push_back({2'b11, b_idx, 2'b00});
        stream.push_back({2'b11, a_idx, lane});
        exp_q.push_back(mregs[b_idx][23:0] +
                        (wide ? {{8{part[15]}}, part[15:0]} : sext8(part[7:0])));
    endfunction

    function automatic void add_step(input logic pre, input logic [3:0] idx,
                                     input logic [1:0] step);
        logic [31:0] amount;
        amount = 32'd1 << step;
        stream.push_back(pre ? 8'h44 : 8'h45);
        stream.push_back({2'b11, idx, step});
        if (pre)
            mregs[idx] = mregs[idx] - amount;
        exp_q.push_back(mregs[idx][23:0]);
        if (!pre)
            mregs[idx] = mregs[idx] + amount;
    endfunction

    task automatic run_request(input logic [23:0] want);
        int waited;
        @(posedge clk);
        exp_addr <= want;
        idx_en   <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ea_valid && waited < 50);
        if (!ea_valid)
            abort_run("timed out waiting for ea_valid");
        @(posedge clk);
        idx_en <= 1'b0;
        @(posedge clk);                 // Request low for a cycle
    endtask

    initial begin
        int unsigned r;
        void'($urandom(32'h88a8_4326));
        rst         = 1'b1;
        idx_en      = 1'b0;
        reg_wr      = 1'b0;
        reg_wr_code = 8'h00;
        reg_wr_data = 32'h0;
        exp_addr    = 24'h0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            assert (byte_space == `OPQ_DEPTH)
                else report_value("byte_space", byte_space, `OPQ_DEPTH);
        end
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            mregs[i] = $urandom;
            reg_wr      <= 1'b1;
            reg_wr_code <= {2'b11, i[3:0], 2'b00};
            reg_wr_data <= mregs[i];
        end
        @(posedge clk);
        reg_wr <= 1'b0;
        for (int i = 0; i < 6; i++)
            add_short(3'($urandom), i[0], 8'($urandom));
        for (int n = 1; n <= 3; n++) begin
            add_abs(n, 24'($urandom));
            add_abs(n, 24'($urandom));
        end
        for (int i = 0; i < 4; i++)
            add_ext(4'($urandom), i[0], 16'($urandom));
        for (int i = 0; i < 4; i++)
            add_pair(i[0], 4'($urandom), 4'($urandom),
                     i[0] ? {1'($urandom), 1'b0} : 2'($urandom));
        // Each step update is read back through a plain (r32)
        for (int s = 0; s < 3; s++) begin
            r = $urandom % 16;
            add_step(1'b1, 4'(r), 2'(s));
            add_ext(4'(r), 1'b0, 16'h0);
            add_step(1'b0, 4'(r), 2'(s));
            add_ext(4'(r), 1'b0, 16'h0);
        end
        repeat (4) stream.push_back(8'h00);   // Keeps the last window full
        feed_on <= 1'b1;
        while (exp_q.size() > 0)
            run_request(exp_q.pop_front());
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* ea_unit.f */
+incdir+common
common/cpu_regs_pkg.sv
common/ea_pkg.sv
source/op_queue.sv
source/reg_bank.sv
ea_decode/ea_decode.sv
source/ea_unit.sv
dv/ea_unit_tb.sv
